//--- build.f
+incdir+logic
+incdir+dv
logic/exec_pkg.sv
logic/exec_alu.sv
logic/exec_branch.sv
logic/exec_decode.sv
logic/exec_execute.sv
logic/exec_top.sv
dv/exec_tb.sv

//--- dv/exec_tb_tasks.svh
`ifndef EXEC_TB_TASKS_SVH
`define EXEC_TB_TASKS_SVH

task automatic drive_instr(input logic [6:0] major, input logic [2:0] f3, input logic [6:0] f7,
                           input logic [31:0] pc, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [31:0] imm,
                           input logic [4:0] rd);
    instr.valid    = 1'b1;
    instr.pc       = pc;
    instr.opcode   = {major, f3, f7};
    instr.rd       = rd;
    instr.rs1_data = rs1;
    instr.rs2_data = rs2;
    instr.imm      = imm;
endtask

// one instruction in, wait for its result
task automatic run_instr(input logic [6:0] major, input logic [2:0] f3, input logic [6:0] f7,
                         input logic [31:0] pc, input logic [31:0] rs1,
                         input logic [31:0] rs2, input logic [31:0] imm,
                         input logic [4:0] rd, output exec_res_t got);
    int cycles;
    drive_instr(major, f3, f7, pc, rs1, rs2, imm, rd);
    @(negedge CLK);
    instr.valid = 1'b0;
    cycles      = 1;
    while (!res.valid && cycles < TIMEOUT) begin
        @(negedge CLK);
        cycles++;
    end
    if (!res.valid)
        abort_run($sformatf("no valid result for pc %h within %0d cycles", pc, TIMEOUT));
    if (cycles != 2) begin
        $display("result for pc %h took %0d cycles instead of 2", pc, cycles);
        errors++;
    end
    got = res;
    check_pc($sformatf("instr at %h", pc), pc, got.pc);
endtask

task automatic check_flag(input string tag, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s exp %h act %h", tag, exp, act);
        errors++;
    end
endtask

task automatic check_pc(input string tag, input logic [`EXEC_XLEN-1:0] exp,
                        input logic [`EXEC_XLEN-1:0] act);
    if (act !== exp) begin
        $display("ERR %s res.pc exp %h act %h", tag, exp, act);
        errors++;
    end
endtask

task automatic check_reg_w(input string tag, input reg_w_t exp, input reg_w_t act);
    if (act.en !== exp.en || (exp.en && (act.rd !== exp.rd || act.data !== exp.data))) begin
        $display("ERR %s res.reg_w exp %h act %h", tag, exp, act);
        errors++;
    end
endtask

task automatic check_mem_r(input string tag, input mem_r_t exp, input mem_r_t act);
    if (act.en !== exp.en || (exp.en && act !== exp)) begin
        $display("ERR %s res.mem_r exp %h act %h", tag, exp, act);
        errors++;
    end
endtask

task automatic check_mem_w(input string tag, input mem_w_t exp, input mem_w_t act);
    if (act.en !== exp.en || (exp.en && act !== exp)) begin
        $display("ERR %s res.mem_w exp %h act %h", tag, exp, act);
        errors++;
    end
endtask

task automatic check_jmp(input string tag, input jmp_t exp, input jmp_t act);
    if (act.taken !== exp.taken || act.not_taken !== exp.not_taken ||
        ((exp.taken || exp.not_taken) && act.target !== exp.target)) begin
        $display("ERR %s res.jmp exp %h act %h", tag, exp, act);
        errors++;
    end
endtask

task automatic check_res(input string tag, input reg_w_t exp_w, input mem_r_t exp_r,
                         input mem_w_t exp_m, input jmp_t exp_j, input exec_res_t got);
    check_flag({tag, " res.valid"}, 1'b1, got.valid);
    check_reg_w(tag, exp_w, got.reg_w);
    check_mem_r(tag, exp_r, got.mem_r);
    check_mem_w(tag, exp_m, got.mem_w);
    check_jmp(tag, exp_j, got.jmp);
endtask

// no valid result and every enable low
task automatic check_idle(input string tag);
    check_flag({tag, " res.valid"}, 1'b0, res.valid);
    check_reg_w(tag, '0, res.reg_w);
    check_mem_r(tag, '0, res.mem_r);
    check_mem_w(tag, '0, res.mem_w);
    check_jmp(tag, '0, res.jmp);
endtask

`endif

//--- dv/exec_tb.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_tb import exec_pkg::*; ();

    localparam int TIMEOUT = 20;    // cycles per wait

    logic      CLK;
    logic      arst_n;
    logic      hold;
    logic      flush;
    instr_t    instr;
    exec_res_t res;
    int        errors;

    exec_top dut_i (
        .CLK    (CLK),
        .arst_n (arst_n),
        .hold   (hold),
        .flush  (flush),
        .instr  (instr),
        .res    (res)
    );

    always #20 CLK = ~CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        errors++;
        $display("errors: %0d", errors);
        $display("TEST FAILED");
        $finish;
    endtask

    `include "exec_tb_tasks.svh"

    function automatic logic [31:0] sext_i(input logic [31:0] imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    // rv32i integer semantics
    function automatic logic [31:0] model_alu(input logic [6:0] major, input logic [2:0] f3,
                                              input logic [6:0] f7, input logic [31:0] pc,
                                              input logic [31:0] a, input logic [31:0] rs2,
                                              input logic [31:0] imm);
        logic [31:0] b;
        logic [31:0] r;
        b = (major == OP_REG) ? rs2 : sext_i(imm);
        if (major == LUI)
            return {imm[31:12], 12'h0};
        if (major == AUIPC)
            return pc + {imm[31:12], 12'h0};
        if (major == JAL || major == JALR)
            return pc + `EXEC_LINK_OFS;
        case (f3)
            3'd0: r = (major == OP_REG && f7[5]) ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (f7[5])
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic test_reset();
        arst_n = 1'b0;
        repeat (4) begin
            @(negedge CLK);
            check_idle("reset");
        end
        arst_n = 1'b1;
        @(negedge CLK);
        check_idle("after reset");
    endtask

    task automatic test_integer();
        logic [16:0] code;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [4:0]  rd;
        reg_w_t      exp_w;
        exec_res_t   got;
        for (int i = 0; i < 21; i++) begin
            if (i < 8)
                code = {OP_REG, 3'(i), 7'h00};
            else if (i == 8)
                code = {OP_REG, 3'd0, 7'h20};   // sub
            else if (i == 9)
                code = {OP_REG, 3'd5, 7'h20};   // sra
            else if (i < 18)
                code = {OP_IMM, 3'(i - 10), 7'h00};
            else if (i == 18)
                code = {OP_IMM, 3'd5, 7'h20};   // srai
            else
                code = {(i == 19) ? LUI : AUIPC, 10'h0};
            pc  = $urandom & 32'hffff_fffc;
            a   = $urandom;
            b   = $urandom;
            imm = $urandom;
            rd  = $urandom;
            if (code[16:10] == OP_IMM && code[8:7] == 2'b01)
                imm[11:5] = code[6:0];
            run_instr(code[16:10], code[9:7], code[6:0], pc, a, b, imm, rd, got);
            exp_w      = '0;
            exp_w.en   = 1'b1;
            exp_w.rd   = rd;
            exp_w.data = model_alu(code[16:10], code[9:7], code[6:0], pc, a, b, imm);
            check_res($sformatf("int %0d", i), exp_w, '0, '0, '0, got);
        end
    endtask

    task automatic test_jumps();
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] imm;
        reg_w_t      exp_w;
        jmp_t        exp_j;
        exec_res_t   got;
        for (int k = 0; k < 4; k++) begin
            pc  = $urandom & 32'hffff_fffc;
            a   = $urandom;
            imm = $urandom;
            run_instr((k < 2) ? JAL : JALR, 3'd0, 7'd0, pc, a, 32'd0, imm, 5'd1, got);
            exp_w       = '0;
            exp_w.en    = 1'b1;
            exp_w.rd    = 5'd1;
            exp_w.data  = pc + `EXEC_LINK_OFS;
            exp_j       = '0;
            exp_j.taken = 1'b1;
            if (k < 2)
                exp_j.target = pc + {{11{imm[20]}}, imm[20:1], 1'b0};
            else
                exp_j.target = (a + sext_i(imm)) & ~32'h1;
            check_res($sformatf("jump %0d", k), exp_w, '0, '0, exp_j, got);
        end
    endtask

    task automatic test_branches();
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] imm;
        jmp_t        exp_j;
        exec_res_t   got;
        for (int j = 0; j < 6; j++) begin
            f3 = (j < 2) ? 3'(j) : 3'(j + 2);
            for (int k = 0; k < 5; k++) begin
                case (k)
                    0: begin a = 32'h0000_1234; b = 32'h0000_1234; end
                    1: begin a = 32'd3;         b = 32'd9;         end
                    2: begin a = 32'h8000_0000; b = 32'h7fff_ffff; end  // sign boundary
                    3: begin a = 32'hffff_ffff; b = 32'd1;         end
                    default: begin a = 32'd9;   b = 32'd3;         end
                endcase
                pc  = $urandom & 32'hffff_fffc;
                imm = $urandom;
                run_instr(BRANCH, f3, 7'd0, pc, a, b, imm, 5'd0, got);
                exp_j           = '0;
                exp_j.taken     = branch_cond(f3, a, b);
                exp_j.not_taken = !exp_j.taken;
                exp_j.target    = pc + {{19{imm[12]}}, imm[12:1], 1'b0};
                check_res($sformatf("branch f3=%0d pair %0d", f3, k), '0, '0, '0, exp_j, got);
            end
        end
    endtask

    task automatic test_memory();
        logic [2:0]  f3;
        logic        is_load;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [4:0]  rd;
        mem_r_t      exp_r;
        mem_w_t      exp_m;
        exec_res_t   got;
        for (int j = 0; j < 8; j++) begin
            is_load = j < 5;
            if (is_load)
                f3 = (j < 3) ? 3'(j) : 3'(j + 1);
            else
                f3 = 3'(j - 5);
            a   = $urandom;
            b   = $urandom;
            imm = $urandom;
            rd  = $urandom;
            run_instr(is_load ? LOAD : STORE, f3, 7'd0, 32'h200, a, b, imm, rd, got);
            exp_r      = '0;
            exp_m      = '0;
            exp_r.addr = a + sext_i(imm);
            exp_r.strb = (f3[1:0] == 2'd0) ? 4'h1 : (f3[1:0] == 2'd1) ? 4'h3 : 4'hf;
            exp_m.addr = exp_r.addr;
            exp_m.strb = exp_r.strb;
            if (is_load) begin
                exp_r.en   = 1'b1;
                exp_r.rd   = rd;
                exp_r.sign = !f3[2] && f3[1:0] != 2'd2;  // lb, lh
                exp_m      = '0;
            end else begin
                exp_m.en   = 1'b1;
                exp_m.data = b;
            end
            check_res($sformatf("mem %0d", j), '0, exp_r, exp_m, '0, got);
        end
    endtask

    task automatic test_pipeline();
        exec_res_t snap;
        reg_w_t    exp_w;
        int        n;
        drive_instr(OP_REG, 3'd0, 7'd0, 32'h100, 32'd5, 32'd7, 32'd0, 5'd1);
        @(negedge CLK);
        drive_instr(OP_REG, 3'd4, 7'd0, 32'h104, 32'hf0, 32'h0f, 32'd0, 5'd2);
        @(negedge CLK);
        instr.valid = 1'b0;
        hold        = 1'b1;
        exp_w       = '{en: 1'b1, rd: 5'd1, data: 32'd12};
        check_res("first of pair", exp_w, '0, '0, '0, res);
        check_pc("first of pair", 32'h100, res.pc);
        snap = res;
        repeat (3) begin
            @(negedge CLK);
            if (res !== snap) begin
                $display("res changed while hold was high");
                errors++;
            end
        end
        hold = 1'b0;
        n    = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (res.pc === snap.pc && n < TIMEOUT);
        if (res.pc === snap.pc)
            abort_run("second instruction did not leave the pipeline after hold");
        exp_w = '{en: 1'b1, rd: 5'd2, data: 32'hff};
        check_res("second of pair", exp_w, '0, '0, '0, res);
        check_pc("second of pair", 32'h104, res.pc);

        // flush with one in res and one in decode
        drive_instr(OP_REG, 3'd6, 7'd0, 32'h300, 32'd1, 32'd2, 32'd0, 5'd3);
        @(negedge CLK);
        drive_instr(OP_REG, 3'd7, 7'd0, 32'h304, 32'd3, 32'd6, 32'd0, 5'd4);
        @(negedge CLK);
        instr.valid = 1'b0;
        flush       = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        repeat (3) begin
            check_idle("after flush");
            @(negedge CLK);
        end

        run_instr(7'h7f, 3'd0, 7'd0, 32'h400, 32'd1, 32'd2, 32'd3, 5'd5, snap);
        check_res("undefined opcode", '0, '0, '0, '0, snap);
    endtask

    initial begin
        void'($urandom(80648));
        CLK    = 1'b0;
        arst_n = 1'b0;
        hold   = 1'b0;
        flush  = 1'b0;
        instr  = '0;
        errors = 0;
        test_reset();
        test_integer();
        test_jumps();
        test_branches();
        test_memory();
        test_pipeline();
        repeat (2) @(negedge CLK);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- logic/exec_top.sv
`timescale 1ns/10ps

module exec_top import exec_pkg::*; (
    input  logic      CLK,
    input  logic      arst_n,
    input  logic      hold,     // freezes both stages
    input  logic      flush,    // beats hold
    input  instr_t    instr,
    output exec_res_t res
);

    dec_t dec;

    exec_decode u_decode (
        .CLK    (CLK),
        .arst_n (arst_n),
        .hold   (hold),
        .flush  (flush),
        .instr  (instr),
        .dec    (dec)
    );

    exec_execute u_execute (
        .CLK    (CLK),
        .arst_n (arst_n),
        .hold   (hold),
        .flush  (flush),
        .dec    (dec),
        .res    (res)
    );

endmodule

//--- logic/exec_execute.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_execute import exec_pkg::*; (
    input  logic      CLK,
    input  logic      arst_n,
    input  logic      hold,
    input  logic      flush,
    input  dec_t      dec,
    output exec_res_t res
);

    logic [`EXEC_XLEN-1:0]   alu_result;
    logic                    alu_writes;
    jmp_t                    br_jmp;
    logic [`EXEC_XLEN-1:0]   mem_addr;
    logic [`EXEC_STRB_W-1:0] mem_strb;
    logic                    is_load;
    logic                    is_store;
    logic                    mem_sign;
    exec_res_t               res_d;
    exec_res_t               res_q;
    logic [5:0]              flags_d;
    logic [5:0]              flags_q;

    exec_alu u_alu (
        .dec    (dec),
        .result (alu_result),
        .writes (alu_writes)
    );

    exec_branch u_branch (
        .dec (dec),
        .jmp (br_jmp)
    );

    assign mem_addr = dec.rs1_data + dec.imm_i;
    assign is_load  = dec.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    assign is_store = dec.op inside {OP_SB, OP_SH, OP_SW};
    assign mem_sign = dec.op inside {OP_LB, OP_LH};

    always_comb begin
        case (dec.op)
            OP_LB, OP_LBU, OP_SB: mem_strb = `EXEC_STRB_W'('h1);
            OP_LH, OP_LHU, OP_SH: mem_strb = `EXEC_STRB_W'('h3);
            OP_LW, OP_SW:         mem_strb = `EXEC_STRB_W'('hF);
            default:              mem_strb = '0;
        endcase
    end

    always_comb begin
        res_d.valid         = dec.valid;
        res_d.pc            = dec.pc;
        res_d.reg_w.en      = dec.valid && alu_writes;
        res_d.reg_w.rd      = dec.rd;
        res_d.reg_w.data    = alu_result;
        res_d.mem_r.en      = dec.valid && is_load;
        res_d.mem_r.rd      = dec.rd;
        res_d.mem_r.addr    = mem_addr;
        res_d.mem_r.strb    = mem_strb;
        res_d.mem_r.sign    = mem_sign;
        res_d.mem_w.en      = dec.valid && is_store;
        res_d.mem_w.addr    = mem_addr;
        res_d.mem_w.strb    = mem_strb;
        res_d.mem_w.data    = dec.rs2_data;   // store data
        res_d.jmp.taken     = dec.valid && br_jmp.taken;
        res_d.jmp.not_taken = dec.valid && br_jmp.not_taken;
        res_d.jmp.target    = br_jmp.target;
    end

    assign flags_d = {res_d.valid, res_d.reg_w.en, res_d.mem_r.en,
                      res_d.mem_w.en, res_d.jmp.taken, res_d.jmp.not_taken};

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n)
            flags_q <= '0;
        else if (flush)
            flags_q <= '0;
        else if (!hold)
            flags_q <= flags_d;
    end

    always_ff @(posedge CLK) begin
        if (!hold)
            res_q <= res_d;
    end

    always_comb begin
        res = res_q;
        {res.valid, res.reg_w.en, res.mem_r.en,
         res.mem_w.en, res.jmp.taken, res.jmp.not_taken} = flags_q;
    end

endmodule

//--- logic/exec_decode.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_decode import exec_pkg::*; (
    input  logic   CLK,
    input  logic   arst_n,
    input  logic   hold,
    input  logic   flush,
    input  instr_t instr,
    output dec_t   dec
);

    major_e     major;
    logic [2:0] funct3;
    logic [6:0] funct7;
    exec_op_e   op_d;
    dec_t       dec_d;
    dec_t       pl_q;
    logic       valid_q;
    exec_op_e   op_q;

    assign major  = major_e'(instr.opcode[16:10]);
    assign funct3 = instr.opcode[9:7];
    assign funct7 = instr.opcode[6:0];

    always_comb begin
        op_d = OP_NONE;
        if (instr.valid) begin
            case (major)
                OP_REG: begin
                    case ({funct7, funct3})
                        10'b0000000_000: op_d = OP_ADD;
                        10'b0100000_000: op_d = OP_SUB;
                        10'b0000000_001: op_d = OP_SLL;
                        10'b0000000_010: op_d = OP_SLT;
                        10'b0000000_011: op_d = OP_SLTU;
                        10'b0000000_100: op_d = OP_XOR;
                        10'b0000000_101: op_d = OP_SRL;
                        10'b0100000_101: op_d = OP_SRA;
                        10'b0000000_110: op_d = OP_OR;
                        10'b0000000_111: op_d = OP_AND;
                        default:         op_d = OP_NONE;
                    endcase
                end
                OP_IMM: begin
                    case (funct3)
                        3'b000:  op_d = OP_ADDI;
                        3'b010:  op_d = OP_SLTI;
                        3'b011:  op_d = OP_SLTIU;
                        3'b100:  op_d = OP_XORI;
                        3'b110:  op_d = OP_ORI;
                        3'b111:  op_d = OP_ANDI;
                        3'b001:  op_d = (funct7 == 7'b0000000) ? OP_SLLI : OP_NONE;
                        default: begin  // 101, logical or arithmetic by funct7
                            if (funct7 == 7'b0000000)
                                op_d = OP_SRLI;
                            else if (funct7 == 7'b0100000)
                                op_d = OP_SRAI;
                        end
                    endcase
                end
                LUI:    op_d = OP_LUI;
                AUIPC:  op_d = OP_AUIPC;
                JAL:    op_d = OP_JAL;
                JALR:   op_d = (funct3 == 3'b000) ? OP_JALR : OP_NONE;
                BRANCH: begin
                    case (funct3)
                        3'b000:  op_d = OP_BEQ;
                        3'b001:  op_d = OP_BNE;
                        3'b100:  op_d = OP_BLT;
                        3'b101:  op_d = OP_BGE;
                        3'b110:  op_d = OP_BLTU;
                        3'b111:  op_d = OP_BGEU;
                        default: op_d = OP_NONE;
                    endcase
                end
                LOAD: begin
                    case (funct3)
                        3'b000:  op_d = OP_LB;
                        3'b001:  op_d = OP_LH;
                        3'b010:  op_d = OP_LW;
                        3'b100:  op_d = OP_LBU;
                        3'b101:  op_d = OP_LHU;
                        default: op_d = OP_NONE;
                    endcase
                end
                STORE: begin
                    case (funct3)
                        3'b000:  op_d = OP_SB;
                        3'b001:  op_d = OP_SH;
                        3'b010:  op_d = OP_SW;
                        default: op_d = OP_NONE;
                    endcase
                end
                default: op_d = OP_NONE;
            endcase
        end
    end

    always_comb begin
        dec_d.valid    = instr.valid;
        dec_d.op       = op_d;
        dec_d.pc       = instr.pc;
        dec_d.rd       = instr.rd;
        dec_d.rs1_data = instr.rs1_data;
        dec_d.rs2_data = instr.rs2_data;
        dec_d.imm_i    = {{(`EXEC_XLEN-12){instr.imm[11]}}, instr.imm[11:0]};
        dec_d.imm_u    = {instr.imm[`EXEC_XLEN-1:12], 12'b0};
        if (major == JAL)   // 21-bit jump offset
            dec_d.imm_b = {{(`EXEC_XLEN-21){instr.imm[20]}}, instr.imm[20:1], 1'b0};
        else
            dec_d.imm_b = {{(`EXEC_XLEN-13){instr.imm[12]}}, instr.imm[12:1], 1'b0};
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            op_q    <= OP_NONE;
        end else if (flush) begin
            valid_q <= 1'b0;
            op_q    <= OP_NONE;
        end else if (!hold) begin
            valid_q <= dec_d.valid;
            op_q    <= dec_d.op;
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold)
            pl_q <= dec_d;
    end

    always_comb begin
        dec       = pl_q;
        dec.valid = valid_q;
        dec.op    = op_q;
    end

endmodule

//--- logic/exec_branch.sv
`timescale 1ns/10ps

module exec_branch import exec_pkg::*; (
    input  dec_t dec,
    output jmp_t jmp
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = dec.rs1_data == dec.rs2_data;
    assign lt_s = $signed(dec.rs1_data) < $signed(dec.rs2_data);
    assign lt_u = dec.rs1_data < dec.rs2_data;

    always_comb begin
        case (dec.op)
            OP_BEQ:  cond = eq;
            OP_BNE:  cond = !eq;
            OP_BLT:  cond = lt_s;
            OP_BGE:  cond = !lt_s;
            OP_BLTU: cond = lt_u;
            OP_BGEU: cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        jmp = '0;
        case (dec.op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                jmp.taken     = cond;
                jmp.not_taken = !cond;
                jmp.target    = dec.pc + dec.imm_b;
            end
            OP_JAL: begin
                jmp.taken  = 1'b1;
                jmp.target = dec.pc + dec.imm_b;
            end
            OP_JALR: begin
                jmp.taken     = 1'b1;
                jmp.target    = dec.rs1_data + dec.imm_i;
                jmp.target[0] = 1'b0;   // lsb always cleared
            end
            default: jmp = '0;
        endcase
    end

endmodule

//--- logic/exec_alu.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_alu import exec_pkg::*; (
    input  dec_t                  dec,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                  writes
);

    logic [`EXEC_XLEN-1:0] opb;
    logic [4:0]            shamt;
    logic                  lt_s;
    logic                  lt_u;

    // register forms take rs2, immediate forms take imm_i
    always_comb begin
        case (dec.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU: opb = dec.rs2_data;
            default:                                 opb = dec.imm_i;
        endcase
    end

    assign shamt = opb[4:0];
    assign lt_s  = $signed(dec.rs1_data) < $signed(opb);
    assign lt_u  = dec.rs1_data < opb;

    always_comb begin
        writes = 1'b1;
        case (dec.op)
            OP_ADD, OP_ADDI:   result = dec.rs1_data + opb;
            OP_SUB:            result = dec.rs1_data - opb;
            OP_AND, OP_ANDI:   result = dec.rs1_data & opb;
            OP_OR, OP_ORI:     result = dec.rs1_data | opb;
            OP_XOR, OP_XORI:   result = dec.rs1_data ^ opb;
            OP_SLL, OP_SLLI:   result = dec.rs1_data << shamt;
            OP_SRL, OP_SRLI:   result = dec.rs1_data >> shamt;
            OP_SRA, OP_SRAI:   result = $signed(dec.rs1_data) >>> shamt;
            OP_SLT, OP_SLTI:   result = `EXEC_XLEN'(lt_s);
            OP_SLTU, OP_SLTIU: result = `EXEC_XLEN'(lt_u);
            OP_LUI:            result = dec.imm_u;
            OP_AUIPC:          result = dec.pc + dec.imm_u;
            OP_JAL, OP_JALR:   result = dec.pc + `EXEC_XLEN'(`EXEC_LINK_OFS);    // link
            default: begin     // branches, loads, stores, none
                result = '0;
                writes = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/exec_pkg.sv
`include "exec_cfg.svh"

package exec_pkg;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP_REG = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } major_e;

    typedef enum logic [5:0] {
        OP_NONE = 6'd0,     // must stay zero
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW
    } exec_op_e;

    typedef struct packed {
        logic                    valid;
        logic [`EXEC_XLEN-1:0]   pc;
        logic [`EXEC_OPC_W-1:0]  opcode;    // {major, funct3, funct7}
        logic [`EXEC_RAW-1:0]    rd;
        logic [`EXEC_XLEN-1:0]   rs1_data;
        logic [`EXEC_XLEN-1:0]   rs2_data;
        logic [`EXEC_XLEN-1:0]   imm;
    } instr_t;

    typedef struct packed {
        logic                    valid;
        exec_op_e                op;
        logic [`EXEC_XLEN-1:0]   pc;
        logic [`EXEC_RAW-1:0]    rd;
        logic [`EXEC_XLEN-1:0]   rs1_data;
        logic [`EXEC_XLEN-1:0]   rs2_data;
        logic [`EXEC_XLEN-1:0]   imm_i;
        logic [`EXEC_XLEN-1:0]   imm_b;     // branch or jal offset
        logic [`EXEC_XLEN-1:0]   imm_u;
    } dec_t;

    typedef struct packed {
        logic                    en;
        logic [`EXEC_RAW-1:0]    rd;
        logic [`EXEC_XLEN-1:0]   data;
    } reg_w_t;

    typedef struct packed {
        logic                    en;
        logic [`EXEC_RAW-1:0]    rd;
        logic [`EXEC_XLEN-1:0]   addr;
        logic [`EXEC_STRB_W-1:0] strb;
        logic                    sign;
    } mem_r_t;

    typedef struct packed {
        logic                    en;
        logic [`EXEC_XLEN-1:0]   addr;
        logic [`EXEC_STRB_W-1:0] strb;
        logic [`EXEC_XLEN-1:0]   data;
    } mem_w_t;

    typedef struct packed {
        logic                    taken;
        logic                    not_taken;
        logic [`EXEC_XLEN-1:0]   target;
    } jmp_t;

    typedef struct packed {
        logic                    valid;
        logic [`EXEC_XLEN-1:0]   pc;
        reg_w_t                  reg_w;
        mem_r_t                  mem_r;
        mem_w_t                  mem_w;
        jmp_t                    jmp;
    } exec_res_t;

endpackage

//--- logic/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// data and address width
`define EXEC_XLEN 32

// packed opcode: major 7, funct3 3, funct7 7
`define EXEC_OPC_W 17

// register address width
`define EXEC_RAW 5

// one strobe bit per byte
`define EXEC_STRB_W 4

// link value is pc plus this
`define EXEC_LINK_OFS 4

`endif
